//--- tb.f
verilog/trojan_pkg.sv
verilog/mem_array.sv
verilog/trojan_trigger.sv
verilog/mem_host.sv
verilog/trojan_bench_top.sv
test/trojan_bench_props.sv
test/tb_trojan_bench.sv

//--- Makefile
# Verilator build and run of the memory host testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
		--top-module tb_trojan_bench -Mdir obj_dir -o sim -f tb.f
	./obj_dir/sim | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_trojan_bench.sv
/* Testbench for the memory host with its Trojan: clock, reset, directed and
   random requests, reference model, response checker, watchdog and summary */
`timescale 1ns/10ps

module tb_trojan_bench;

    typedef struct packed {
        int                   due;              // Cycle count when rsp is sampled
        logic [2:0]           tag;              // Test that owns the check
        logic                 suppressed;
        logic                 zero_check;       // Read of a word wiped by the Trojan
        trojan_pkg::mem_rsp_t rsp;
    } expect_t;

    logic                 clk = 1'b0;
    logic                 rst;
    trojan_pkg::mem_req_t req;
    trojan_pkg::mem_rsp_t rsp;
    int                   cyc = 0;              // Rising edges seen so far

    // Reference model
    logic [trojan_pkg::data_width-1:0] shadow [trojan_pkg::mem_depth];
    logic                              fresh [trojan_pkg::mem_depth];  // Written since firing
    logic [31:0]                       model_pattern;
    int                                model_matches;
    int                                fire_count;
    logic                              fired_once;

    expect_t exp_q [$];
    logic    checking;
    int      check_count [5];
    int      err_count [5];
    int      zero_reads;
    string   test_names [5];
    int      cur_test;

    int directed_reqs = 44;                     // Requests of tests 1 to 3
    int random_min = 1000;
    int random_max = 4000;                      // Upper bound while waiting for a firing

    trojan_bench_top i_dut (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic trojan_pkg::mem_req_t make_req(input trojan_pkg::mem_op_t op,
                                                      input logic [5:0] addr,
                                                      input logic [15:0] wdata);
        trojan_pkg::mem_req_t r;
        r.strobe = 1'b1;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        return r;
    endfunction

    // Expected response of one accepted request, updates the model state
    function automatic expect_t predict(input trojan_pkg::mem_req_t r);
        expect_t e;
        logic    fb;
        logic    fire;
        fb = model_pattern[31] ^ model_pattern[21] ^ model_pattern[1] ^ model_pattern[0];
        model_pattern = {model_pattern[30:0], fb};
        fire = 1'b0;
        if (model_pattern[7:0] == trojan_pkg::trigger_byte) begin
            model_matches++;
            if (model_matches == trojan_pkg::trigger_count) begin
                fire = 1'b1;
                model_matches = 0;
            end
        end
        e = '0;
        e.tag = 3'(cur_test);
        if (r.addr >= trojan_pkg::mem_depth) begin
            e.rsp.error = 1'b1;                 // Memory untouched, rdata zero
        end else if (r.op == trojan_pkg::op_write) begin
            shadow[r.addr] = r.wdata;
            fresh[r.addr] = 1'b1;
            e.rsp.write_ack = 1'b1;
        end else begin
            e.rsp.read_valid = 1'b1;
            e.rsp.rdata = shadow[r.addr];
            e.zero_check = fired_once && !fresh[r.addr];
        end
        if (fire) begin
            // Forced reset eats this response and wipes the memory
            e.suppressed = 1'b1;
            e.zero_check = 1'b0;
            e.tag = 3'd4;
            fire_count++;
            fired_once = 1'b1;
            for (int i = 0; i < trojan_pkg::mem_depth; i++) begin
                shadow[i] = '0;
                fresh[i] = 1'b0;
            end
        end
        return e;
    endfunction

    task automatic check_response(input expect_t e);
        trojan_pkg::mem_rsp_t want;
        if (e.suppressed) begin
            want = '0;
        end else begin
            want = e.rsp;
        end
        check_count[e.tag]++;
        if (rsp != want) begin
            $display("FAIL %s: expected rsp %h, actual %h", test_names[e.tag], want, rsp);
            err_count[e.tag]++;
        end
        if (e.zero_check) begin
            zero_reads++;
            check_count[4]++;
            if (rsp.rdata != '0) begin
                $display("FAIL %s: expected cleared word %h, actual %h",
                         test_names[4], 16'h0000, rsp.rdata);
                err_count[4]++;
            end
        end
    endtask

    // Compares on every falling edge, silence is expected when nothing is due
    always @(negedge clk) begin : compare
        expect_t e;
        if (checking) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                check_response(e);
            end else if (rsp != '0) begin
                $display("FAIL %s: expected no response %h, actual %h",
                         test_names[cur_test], 19'h0, rsp);
                err_count[cur_test]++;
            end
        end
    end

    // One request every three cycles, optionally chased by a strobe while busy
    task automatic send_request(input trojan_pkg::mem_req_t r, input logic add_busy);
        expect_t e;
        @(negedge clk);
        e = predict(r);
        e.due = cyc + 2;                        // Accepted next edge, answered one later
        exp_q.push_back(e);
        req = r;
        @(negedge clk);
        if (add_busy) begin
            req = make_req(trojan_pkg::op_write, 6'd5, 16'hdead);
        end else begin
            req = '0;
        end
        @(negedge clk);
        req = '0;
    endtask

    task automatic finish_test(input int idx);
        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%s: %0d responses never arrived", test_names[idx], exp_q.size());
            err_count[idx]++;
            exp_q.delete();
        end
        $display("test %0d %s: %0d checks, %0d errors", idx + 1, test_names[idx],
                 check_count[idx], err_count[idx]);
    endtask

    initial begin : watchdog
        int limit;
        limit = 5 + (directed_reqs + random_max) * 4 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog expired: the run did not end within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int          n;
        int          fire_before;
        int          total_checks;
        int          total_errs;
        int          tests_failed;
        rst = 1'b1;
        req = '0;
        checking = 1'b0;
        cur_test = 0;
        zero_reads = 0;
        model_pattern = trojan_pkg::pattern_seed;
        model_matches = 0;
        fire_count = 0;
        fired_once = 1'b0;
        test_names[0] = "directed write read";
        test_names[1] = "out of range";
        test_names[2] = "busy drop";
        test_names[3] = "random traffic";
        test_names[4] = "trojan trigger";
        for (int i = 0; i < 5; i++) begin
            check_count[i] = 0;
            err_count[i] = 0;
        end
        for (int i = 0; i < trojan_pkg::mem_depth; i++) begin
            shadow[i] = '0;
            fresh[i] = 1'b0;
        end
        void'($urandom(32'h8428_e2de));
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checking = 1'b1;

        cur_test = 0;
        send_request(make_req(trojan_pkg::op_write, 6'd0, 16'h1234), 1'b0);
        send_request(make_req(trojan_pkg::op_write, 6'd1, 16'h5a5a), 1'b0);
        send_request(make_req(trojan_pkg::op_write, 6'd47, 16'hbeef), 1'b0);
        send_request(make_req(trojan_pkg::op_read, 6'd0, 16'h0000), 1'b0);
        send_request(make_req(trojan_pkg::op_read, 6'd1, 16'h0000), 1'b0);
        send_request(make_req(trojan_pkg::op_read, 6'd47, 16'h0000), 1'b0);
        finish_test(0);

        cur_test = 1;
        for (int a = 48; a < 64; a++) begin
            send_request(make_req(trojan_pkg::op_write, 6'(a), 16'(a * 3)), 1'b0);
            send_request(make_req(trojan_pkg::op_read, 6'(a), 16'h0000), 1'b0);
        end
        send_request(make_req(trojan_pkg::op_read, 6'd47, 16'h0000), 1'b0);
        send_request(make_req(trojan_pkg::op_read, 6'd0, 16'h0000), 1'b0);
        finish_test(1);

        cur_test = 2;
        send_request(make_req(trojan_pkg::op_write, 6'd10, 16'h0f0f), 1'b1);
        send_request(make_req(trojan_pkg::op_read, 6'd10, 16'h0000), 1'b1);
        send_request(make_req(trojan_pkg::op_read, 6'd5, 16'h0000), 1'b0);
        send_request(make_req(trojan_pkg::op_read, 6'd10, 16'h0000), 1'b0);
        finish_test(2);

        // Keeps going until the Trojan has fired and a wiped word was read back
        cur_test = 3;
        fire_before = fire_count;
        n = 0;
        while (n < random_min ||
               ((fire_count == fire_before || zero_reads == 0) && n < random_max)) begin
            rnd = $urandom();
            send_request(make_req(rnd[0] ? trojan_pkg::op_read : trojan_pkg::op_write,
                                  rnd[6:1], rnd[31:16]), 1'b0);
            n++;
        end
        finish_test(3);

        cur_test = 4;
        if (fire_count == fire_before) begin
            $display("the Trojan never fired during %0d random requests", n);
            err_count[4]++;
        end else if (zero_reads == 0) begin
            $display("no read of a cleared word followed a Trojan firing");
            err_count[4]++;
        end
        $display("test 5 %s: %0d firings, %0d cleared-word reads, %0d checks, %0d errors",
                 test_names[4], fire_count - fire_before, zero_reads,
                 check_count[4], err_count[4]);

        total_checks = 0;
        total_errs = 0;
        tests_failed = 0;
        for (int i = 0; i < 5; i++) begin
            total_checks += check_count[i];
            total_errs += err_count[i];
            if (err_count[i] != 0) begin
                tests_failed++;
            end
        end
        $display("tests 5, failed %0d, checks %0d, errors %0d",
                 tests_failed, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- test/trojan_bench_props.sv
/* Concurrent checks on the host response protocol, bound into mem_host */
`timescale 1ns/10ps

module trojan_bench_props (
    input logic                   clk,
    input logic                   rst,
    input trojan_pkg::mem_state_t state,
    input trojan_pkg::mem_rsp_t   rsp,
    input logic                   force_reset
);

    logic [2:0] pulses;
    logic       any_rsp;

    assign pulses = {rsp.write_ack, rsp.read_valid, rsp.error};
    assign any_rsp = |pulses;

    rsp_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(pulses))
        else $error("more than one response bit high at once");

    // Host is back in idle in the cycle after it answers
    rsp_one_cycle: assert property (@(posedge clk) disable iff (rst) any_rsp |=> !any_rsp)
        else $error("response pulse longer than one cycle");

    rsp_after_idle: assert property (@(posedge clk) disable iff (rst)
        any_rsp |-> ($past(state) != trojan_pkg::st_idle) &&
                    ($past(state, 2) == trojan_pkg::st_idle))
        else $error("response not in the cycle after the host left idle");

    // Forced reset lands in the response cycle of an accepted request
    rsp_quiet_on_trojan: assert property (@(posedge clk) disable iff (rst)
        force_reset |-> !any_rsp && ($past(state) != trojan_pkg::st_idle))
        else $error("force_reset outside a response cycle or with a response");

endmodule

bind mem_host trojan_bench_props i_props (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .rsp         (rsp),
    .force_reset (force_reset)
);

//--- verilog/trojan_bench_top.sv
/* Top level joining the external request and response structs
   to the memory host */
`timescale 1ns/10ps

module trojan_bench_top (
    input  logic                 clk,
    input  logic                 rst,
    input  trojan_pkg::mem_req_t req,
    output trojan_pkg::mem_rsp_t rsp
);

    trojan_pkg::mem_req_t host_req;
    trojan_pkg::mem_rsp_t host_rsp;

    assign host_req = req;
    assign rsp = host_rsp;

    // Host carries the memory and the Trojan
    mem_host i_host (
        .clk (clk),
        .rst (rst),
        .req (host_req),
        .rsp (host_rsp)
    );

endmodule

//--- verilog/mem_host.sv
/* Memory host FSM with range check, pattern register and response
   pulses; holds the memory array and the Trojan */
`timescale 1ns/10ps

module mem_host (
    input  logic                 clk,
    input  logic                 rst,
    input  trojan_pkg::mem_req_t req,
    output trojan_pkg::mem_rsp_t rsp
);

    trojan_pkg::mem_state_t                  state;
    trojan_pkg::mem_rsp_t                    rsp_q;
    logic [trojan_pkg::pattern_width-1:0]    pattern;
    logic [trojan_pkg::addr_width-1:0]       addr_q;
    logic [trojan_pkg::data_width-1:0]       wdata_q;
    logic [trojan_pkg::addr_width-1:0]       raddr;
    logic [trojan_pkg::data_width-1:0]       mem_rdata;
    logic                                    accept;
    logic                                    req_addr_ok;
    logic                                    addr_ok;
    logic                                    mem_we;
    logic                                    step;
    logic                                    feedback;
    logic                                    force_reset;

    // Strobes seen while busy are dropped
    assign accept = req.strobe && (state == trojan_pkg::st_idle);

    assign req_addr_ok = req.addr < trojan_pkg::addr_limit;
    assign addr_ok = addr_q < trojan_pkg::addr_limit;

    // Read starts at acceptance so the word is ready for the response
    assign raddr = req_addr_ok ? req.addr : '0;
    assign mem_we = (state == trojan_pkg::st_write) && addr_ok;

    assign step = (state != trojan_pkg::st_idle);   // One cycle per accepted request
    assign feedback = pattern[31] ^ pattern[21] ^ pattern[1] ^ pattern[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= trojan_pkg::st_idle;
        end else begin
            case (state)
                trojan_pkg::st_idle: begin
                    if (req.strobe) begin
                        state <= (req.op == trojan_pkg::op_write) ?
                                 trojan_pkg::st_write : trojan_pkg::st_read;
                    end
                end
                default: state <= trojan_pkg::st_idle;  // Write and read take one cycle
            endcase
        end
    end

    // Steps on accepted requests only, untouched by force_reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= trojan_pkg::pattern_seed;
        end else if (accept) begin
            pattern <= {pattern[trojan_pkg::pattern_width-2:0], feedback};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req.addr;
            wdata_q <= req.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= '0;                        // Pulses last one cycle
            case (state)
                trojan_pkg::st_write: begin
                    rsp_q.write_ack <= addr_ok;
                    rsp_q.error <= !addr_ok;
                end
                trojan_pkg::st_read: begin
                    rsp_q.read_valid <= addr_ok;
                    rsp_q.error <= !addr_ok;
                    rsp_q.rdata <= addr_ok ? mem_rdata : '0;
                end
                default: ;
            endcase
        end
    end

    // Trojan firing swallows the response of the request in flight
    always_comb begin
        if (force_reset) begin
            rsp = '0;
        end else begin
            rsp = rsp_q;
        end
    end

    mem_array i_mem (
        .clk   (clk),
        .rst   (rst),
        .clear (force_reset),
        .we    (mem_we),
        .waddr (addr_q),
        .wdata (wdata_q),
        .raddr (raddr),
        .rdata (mem_rdata)
    );

    trojan_trigger i_trojan (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .data_in     (pattern[7:0]),            // Stepped low byte
        .force_reset (force_reset)
    );

endmodule

//--- verilog/trojan_trigger.sv
/* Trojan payload that counts pattern byte matches and pulses
   a forced reset on the last one */
`timescale 1ns/10ps

module trojan_trigger (
    input  logic       clk,
    input  logic       rst,
    input  logic       step,
    input  logic [7:0] data_in,
    output logic       force_reset
);

    logic [trojan_pkg::match_cnt_width-1:0] match_cnt;
    logic                                   hit;
    logic                                   fire;

    // Only stepped bytes are looked at
    assign hit = step && (data_in == trojan_pkg::trigger_byte);
    assign fire = hit && (match_cnt == trojan_pkg::match_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_cnt <= '0;
        end else if (fire) begin
            match_cnt <= '0;                    // Start over after firing
        end else if (hit) begin
            match_cnt <= match_cnt + 1'b1;
        end
    end

    // Registered so the pulse lands one cycle after the step
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            force_reset <= 1'b0;
        end else begin
            force_reset <= fire;
        end
    end

endmodule

//--- verilog/mem_array.sv
/* Register-file memory with a synchronous write port, a registered
   read port and a single-cycle clear of every word */
`timescale 1ns/10ps

module mem_array (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              clear,
    input  logic                              we,
    input  logic [trojan_pkg::addr_width-1:0] waddr,
    input  logic [trojan_pkg::data_width-1:0] wdata,
    input  logic [trojan_pkg::addr_width-1:0] raddr,
    output logic [trojan_pkg::data_width-1:0] rdata
);

    logic [trojan_pkg::data_width-1:0] mem [trojan_pkg::mem_depth];

    // Addresses are range checked by the host
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < trojan_pkg::mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (clear) begin               // Clear wins over a write
            for (int i = 0; i < trojan_pkg::mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read register follows raddr every cycle
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- verilog/trojan_pkg.sv
/* Shared widths, Trojan trigger constants, request and response structs
   and the host state and opcode enums */
package trojan_pkg;

    localparam int data_width = 16;                 // Memory word
    localparam int addr_width = 6;
    localparam int mem_depth = 48;                  // Valid words, the rest raise error
    localparam logic [addr_width-1:0] addr_limit = addr_width'(mem_depth);

    // Pattern register
    localparam int pattern_width = 32;
    localparam logic [pattern_width-1:0] pattern_seed = 32'hDEADBEEF;

    localparam logic [7:0] trigger_byte = 8'hA5;    // Low pattern byte that counts
    localparam int trigger_count = 2;               // Matches until forced reset
    localparam int match_cnt_width = $clog2(trigger_count + 1);
    localparam logic [match_cnt_width-1:0] match_last =
        match_cnt_width'(trigger_count - 1);

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } mem_op_t;

    // Host FSM
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_write = 2'd1,
        st_read  = 2'd2
    } mem_state_t;

    // One request per strobe, 24 bits
    typedef struct packed {
        logic                  strobe;
        mem_op_t               op;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    // One-cycle response pulses, 19 bits
    typedef struct packed {
        logic                  write_ack;
        logic                  read_valid;
        logic                  error;              // Address at or above mem_depth
        logic [data_width-1:0] rdata;              // Zero unless read_valid
    } mem_rsp_t;

endpackage
